// ==== list.f ====
+incdir+design
design/rv_pkg.sv
design/rv_alu.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_branch_unit.sv
design/rv_exec_top.sv
bench/rv_exec_tb.sv

// ==== bench/rv_exec_tb.sv ====
//**********************************************************************
// testbench for the RV32I execute slice driving a table in a loop
//**********************************************************************
`include "rv_consts.svh"

module rv_exec_tb
	import rv_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 8;
	localparam int SLACK_CYCLES = 20;

	// one table row holds stimulus and hand-derived expectations
	typedef struct packed {
		logic             valid;
		logic [31:0]      instr;
		logic [`XLEN-1:0] pc;
		wb_t              exp_wb;
		logic [`XLEN-1:0] exp_npc;
		logic             exp_ill;
	} vec_t;

	logic             clk;
	logic             rst_n;
	logic             instr_valid;
	logic [31:0]      instr;
	logic [`XLEN-1:0] pc;
	wb_t              wb;
	logic [`XLEN-1:0] next_pc;
	logic             illegal;

	vec_t vecs[$];
	int   cycles = 0;
	int   limit = 0;   // set once the table is built

	rv_exec_top u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.wb          (wb),
		.next_pc     (next_pc),
		.illegal     (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;   // 40 ns period
	end

	// instruction assemblers following the RV32I formats
	function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
			input logic [2:0] f3, input int rd);
		r_type = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP};
	endfunction

	function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
			input int rd, input logic [6:0] opc);
		i_type = {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic logic [31:0] b_type(input int off, input int rs2, input int rs1,
			input logic [2:0] f3);
		logic [12:0] im;
		im     = off[12:0];
		b_type = {im[12], im[10:5], rs2[4:0], rs1[4:0], f3, im[4:1], im[11], BRANCH};
	endfunction

	function automatic logic [31:0] j_type(input int off, input int rd);
		logic [20:0] im;
		im     = off[20:0];
		j_type = {im[20], im[10:1], im[11], im[19:12], rd[4:0], JAL};
	endfunction

	// register-writing op at a random aligned pc that falls through to pc + 4
	task automatic result_entry(input logic [31:0] word, input int rd, input logic [31:0] data);
		vec_t v;
		v.valid   = 1'b1;
		v.instr   = word;
		v.pc      = $urandom & 32'hffff_fffc;
		v.exp_wb  = '{valid: 1'b1, rd: rd[4:0], data: data};
		v.exp_npc = v.pc + 32'd4;
		v.exp_ill = 1'b0;
		vecs.push_back(v);
	endtask

	// control flow at a fixed pc with the wb record given by the caller
	task automatic flow_entry(input logic [31:0] word, input logic [31:0] at, input wb_t exp,
			input logic [31:0] npc);
		vec_t v;
		v.valid   = 1'b1;
		v.instr   = word;
		v.pc      = at;
		v.exp_wb  = exp;
		v.exp_npc = npc;
		v.exp_ill = 1'b0;
		vecs.push_back(v);
	endtask

	task automatic illegal_entry(input logic [31:0] word);
		vec_t v;
		v.valid   = 1'b1;
		v.instr   = word;
		v.pc      = $urandom & 32'hffff_fffc;
		v.exp_wb  = '0;
		v.exp_npc = v.pc + 32'd4;   // no redirect on illegal
		v.exp_ill = 1'b1;
		vecs.push_back(v);
	endtask

	task automatic idle_entry();
		vec_t v;
		v         = '0;
		v.exp_npc = vecs[$].exp_npc;   // next_pc holds
		vecs.push_back(v);
	endtask

	task automatic build_table();
		// setup loads x1 = 0x8000_0000, x2 = 5, x3 = -1, x4 = 31 and x5 = 32
		result_entry({20'h80000, 5'd1, LUI}, 1, 32'h8000_0000);
		result_entry(i_type(5, 0, 3'b000, 2, OP_IMM), 2, 32'h5);
		result_entry(i_type(-1, 0, 3'b000, 3, OP_IMM), 3, 32'hffff_ffff);
		result_entry(i_type(31, 0, 3'b000, 4, OP_IMM), 4, 32'h1f);
		result_entry(i_type(32, 0, 3'b000, 5, OP_IMM), 5, 32'h20);
		// register-register
		result_entry(r_type(7'h00, 2, 1, 3'b000, 6), 6, 32'h8000_0005);    // add
		result_entry(r_type(7'h20, 3, 2, 3'b000, 7), 7, 32'h6);            // sub 5 - (-1)
		result_entry(r_type(7'h00, 3, 1, 3'b100, 8), 8, 32'h7fff_ffff);    // xor
		result_entry(r_type(7'h00, 1, 2, 3'b110, 9), 9, 32'h8000_0005);    // or
		result_entry(r_type(7'h00, 2, 3, 3'b111, 10), 10, 32'h5);          // and
		result_entry(r_type(7'h00, 2, 1, 3'b010, 11), 11, 32'h1);          // slt with negative < 5
		result_entry(r_type(7'h00, 2, 1, 3'b011, 12), 12, 32'h0);          // sltu sees big > 5
		result_entry(r_type(7'h00, 3, 2, 3'b010, 13), 13, 32'h0);
		result_entry(r_type(7'h00, 3, 2, 3'b011, 14), 14, 32'h1);
		result_entry(r_type(7'h00, 4, 2, 3'b001, 15), 15, 32'h8000_0000);  // sll by 31
		result_entry(r_type(7'h00, 5, 2, 3'b001, 16), 16, 32'h5);          // 32 masks to 0
		result_entry(r_type(7'h00, 4, 1, 3'b101, 17), 17, 32'h1);          // srl
		result_entry(r_type(7'h20, 4, 1, 3'b101, 18), 18, 32'hffff_ffff);  // sra fills sign
		result_entry(r_type(7'h20, 5, 1, 3'b101, 19), 19, 32'h8000_0000);
		// immediate forms
		result_entry(i_type(32'hff, 2, 3'b100, 20, OP_IMM), 20, 32'hfa);
		result_entry(i_type(0, 3, 3'b010, 21, OP_IMM), 21, 32'h1);
		result_entry(i_type(-1, 2, 3'b011, 22, OP_IMM), 22, 32'h1);        // imm extends to ~0
		result_entry(i_type(32'h404, 1, 3'b101, 23, OP_IMM), 23, 32'hf800_0000);  // srai 4
		result_entry(i_type(32'h7f0, 3, 3'b111, 24, OP_IMM), 24, 32'h7f0);
		result_entry(i_type(32'h123, 1, 3'b110, 25, OP_IMM), 25, 32'h8000_0123);
		result_entry(i_type(28, 3, 3'b101, 26, OP_IMM), 26, 32'hf);
		// x0 write is reported but dropped and reads back as zero
		result_entry(i_type(7, 2, 3'b000, 0, OP_IMM), 0, 32'hc);
		result_entry(r_type(7'h00, 2, 0, 3'b000, 27), 27, 32'h5);
		// each branch taken then not taken
		flow_entry(b_type(16, 10, 2, 3'b000), 32'h200, '0, 32'h210);   // beq
		flow_entry(b_type(16, 3, 2, 3'b000), 32'h204, '0, 32'h208);
		flow_entry(b_type(-8, 3, 2, 3'b001), 32'h208, '0, 32'h200);    // bne
		flow_entry(b_type(-8, 10, 2, 3'b001), 32'h20c, '0, 32'h210);
		flow_entry(b_type(32, 2, 1, 3'b100), 32'h300, '0, 32'h320);    // blt
		flow_entry(b_type(32, 1, 2, 3'b100), 32'h304, '0, 32'h308);
		flow_entry(b_type(64, 1, 2, 3'b101), 32'h308, '0, 32'h348);    // bge
		flow_entry(b_type(64, 2, 1, 3'b101), 32'h30c, '0, 32'h310);
		flow_entry(b_type(12, 1, 2, 3'b110), 32'h400, '0, 32'h40c);    // bltu
		flow_entry(b_type(12, 2, 1, 3'b110), 32'h404, '0, 32'h408);
		flow_entry(b_type(-16, 2, 1, 3'b111), 32'h408, '0, 32'h3f8);   // bgeu
		flow_entry(b_type(-16, 3, 2, 3'b111), 32'h40c, '0, 32'h410);
		// auipc and jal
		flow_entry({20'h12345, 5'd28, AUIPC}, 32'h1000,
			'{valid: 1'b1, rd: 5'd28, data: 32'h1234_6000}, 32'h1004);
		flow_entry(j_type(32'h800, 29), 32'h2000,
			'{valid: 1'b1, rd: 5'd29, data: 32'h2004}, 32'h2800);
		// bad funct7 on xor and a load opcode followed by an idle slot
		illegal_entry(r_type(7'h20, 2, 1, 3'b100, 30));
		illegal_entry(i_type(0, 0, 3'b010, 1, 7'b0000011));
		idle_entry();
		result_entry(r_type(7'h00, 2, 7, 3'b000, 31), 31, 32'hb);   // 6 + 5
	endtask

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic wb_compare(input string tag, input wb_t got, input wb_t exp);
		if (got.valid !== exp.valid)
			stop_with_failure($sformatf("CHECK FAILED wb.valid %s: expected %h, got %h",
				tag, exp.valid, got.valid));
		if (exp.valid && (got.rd !== exp.rd))   // rd and data only mean something when valid
			stop_with_failure($sformatf("CHECK FAILED wb.rd %s: expected %h, got %h",
				tag, exp.rd, got.rd));
		if (exp.valid && (got.data !== exp.data))
			stop_with_failure($sformatf("CHECK FAILED wb.data %s: expected %h, got %h",
				tag, exp.data, got.data));
	endtask

	task automatic word_compare(input string tag, input string name, input logic [`XLEN-1:0] got,
			input logic [`XLEN-1:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED %s %s: expected %h, got %h",
				name, tag, exp, got));
	endtask

	task automatic bit_compare(input string tag, input string name, input logic got,
			input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("CHECK FAILED %s %s: expected %h, got %h",
				name, tag, exp, got));
	endtask

	// watchdog limit covers reset, table and some slack
	always @(posedge clk) begin
		cycles = cycles + 1;
		if ((limit > 0) && (cycles > limit))
			stop_with_failure($sformatf("timeout: run still going after %0d cycles", limit));
	end

	initial begin
		string tag;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = '0;
		void'($urandom(32'h0fe24a5d));
		build_table();
		limit = vecs.size() + RESET_CYCLES + SLACK_CYCLES;

		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		bit_compare("after reset", "wb.valid", wb.valid, 1'b0);
		bit_compare("after reset", "illegal", illegal, 1'b0);
		word_compare("after reset", "next_pc", next_pc, `RESET_PC);

		for (int i = 0; i < vecs.size(); i++) begin
			instr_valid = vecs[i].valid;   // inputs change 2 ns after the edge
			instr       = vecs[i].instr;
			pc          = vecs[i].pc;
			@(posedge clk);
			#2;   // registered outputs settled
			tag = $sformatf("entry %0d", i);
			wb_compare(tag, wb, vecs[i].exp_wb);
			word_compare(tag, "next_pc", next_pc, vecs[i].exp_npc);
			bit_compare(tag, "illegal", illegal, vecs[i].exp_ill);
		end
		instr_valid = 1'b0;

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== design/rv_exec_top.sv ====
//********************************************************************
// execute slice top: decoder, register file, ALU and branch unit
//********************************************************************
`include "rv_consts.svh"

module rv_exec_top
	import rv_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             instr_valid,   // one instruction per strobe
	input  logic [31:0]      instr,
	input  logic [`XLEN-1:0] pc,
	output wb_t              wb,
	output logic [`XLEN-1:0] next_pc,
	output logic             illegal
);

	ctrl_t            ctrl;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	logic [`XLEN-1:0] src1;
	logic [`XLEN-1:0] src2;
	logic [`XLEN-1:0] alu_result;
	logic             alu_zero;
	logic             rf_we;
	logic [`XLEN-1:0] rf_wdata;

	rv_decoder u_decoder (
		.instr (instr),
		.ctrl  (ctrl)
	);

	rv_regfile u_regfile (
		.clk    (clk),
		.rst_n  (rst_n),
		.we     (rf_we),
		.waddr  (ctrl.rd),
		.raddr1 (ctrl.rs1),
		.raddr2 (ctrl.rs2),
		.wdata  (rf_wdata),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data)
	);

	// operands come back from the branch unit's select muxes
	rv_alu u_alu (
		.src1   (src1),
		.src2   (src2),
		.alu_op (ctrl.alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	rv_branch_unit u_branch (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.pc          (pc),
		.ctrl        (ctrl),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.alu_result  (alu_result),
		.alu_zero    (alu_zero),
		.src1        (src1),
		.src2        (src2),
		.rf_we       (rf_we),
		.rf_wdata    (rf_wdata),
		.wb          (wb),
		.next_pc     (next_pc),
		.illegal     (illegal)
	);

endmodule

// ==== design/rv_branch_unit.sv ====
//********************************************************************
// operand select, branch decision, next pc and registered write-back
//********************************************************************
`include "rv_consts.svh"

module rv_branch_unit
	import rv_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             instr_valid,
	input  logic [`XLEN-1:0] pc,
	input  ctrl_t            ctrl,
	input  logic [`XLEN-1:0] rs1_data,
	input  logic [`XLEN-1:0] rs2_data,
	input  logic [`XLEN-1:0] alu_result,
	input  logic             alu_zero,
	output logic [`XLEN-1:0] src1,
	output logic [`XLEN-1:0] src2,
	output logic             rf_we,
	output logic [`XLEN-1:0] rf_wdata,
	output wb_t              wb,
	output logic [`XLEN-1:0] next_pc,
	output logic             illegal
);

	logic             cond;       // raw branch condition
	logic             redirect;   // go to pc + imm
	logic [`XLEN-1:0] link;
	logic [`XLEN-1:0] npc;

	assign src1 = ctrl.src1_pc  ? pc       : rs1_data;
	assign src2 = ctrl.src2_imm ? ctrl.imm : rs2_data;

	// f3[2] picks compare bit over zero, f3[0] inverts (bne, bge, bgeu)
	assign cond = (ctrl.funct3[2] ? alu_result[0] : alu_zero) ^ ctrl.funct3[0];

	assign redirect = !ctrl.illegal && (ctrl.is_jal || (ctrl.is_branch && cond));
	assign link     = pc + 32'd4;
	assign npc      = redirect ? (pc + ctrl.imm) : link;

	assign rf_we    = instr_valid && ctrl.reg_write && !ctrl.illegal && (ctrl.rd != '0);
	assign rf_wdata = ctrl.is_jal ? link : alu_result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb.valid <= 1'b0;
			next_pc  <= `RESET_PC;
			illegal  <= 1'b0;
		end else begin
			wb.valid <= instr_valid && ctrl.reg_write && !ctrl.illegal;   // rd 0 still reported
			illegal  <= instr_valid && ctrl.illegal;
			if (instr_valid) next_pc <= npc;   // holds on idle cycles
		end
		wb.rd   <= ctrl.rd;
		wb.data <= rf_wdata;
	end

	a_no_wb_on_illegal: assert property (@(posedge clk) disable iff (!rst_n)
		(instr_valid && ctrl.illegal) |=> (illegal && !wb.valid))
		else $error("write-back raised for an illegal instruction");

endmodule

// ==== design/rv_regfile.sv ====
//********************************************************************
// 32 x XLEN register file with two async reads and one sync write
//********************************************************************
`include "rv_consts.svh"

module rv_regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               we,
	input  logic [`REG_AW-1:0] waddr,
	input  logic [`REG_AW-1:0] raddr1,
	input  logic [`REG_AW-1:0] raddr2,
	input  logic [`XLEN-1:0]   wdata,
	output logic [`XLEN-1:0]   rdata1,
	output logic [`XLEN-1:0]   rdata2
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;   // all registers read zero after reset
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;   // x0 never written
		end
	end

	// reads see the write of the previous edge without a bypass
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	// x0 reads zero on every cycle out of reset
	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		regs[0] == '0)
		else $error("register x0 was overwritten");

endmodule

// ==== design/rv_decoder.sv ====
//********************************************************************
// RV32I decoder: OP, OP-IMM, LUI, AUIPC, BRANCH and JAL into a
// control record with ALU opcode, operand selects and immediate
//********************************************************************
`include "rv_consts.svh"

module rv_decoder
	import rv_pkg::*;
(
	input  logic [31:0] instr,
	output ctrl_t       ctrl
);

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub / sra

	opcode_e          opc;
	logic [2:0]       funct3;
	logic [6:0]       funct7;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_j;

	assign opc    = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// funct3 to alu op, alt picks sub/sra
	function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  f3_op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  f3_op = ALU_SLL;
			3'b010:  f3_op = ALU_SLT;
			3'b011:  f3_op = ALU_SLTU;
			3'b100:  f3_op = ALU_XOR;
			3'b101:  f3_op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  f3_op = ALU_OR;
			default: f3_op = ALU_AND;
		endcase
	endfunction

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = ALU_ADD;
		ctrl.funct3 = funct3;
		ctrl.rs1    = instr[19:15];
		ctrl.rs2    = instr[24:20];
		ctrl.rd     = instr[11:7];
		ctrl.imm    = imm_i;

		case (opc)
			OP: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op    = f3_op(funct3, funct7 == F7_ALT);
				// alt funct7 only exists for sub and sra
				if (funct7 == F7_ALT) ctrl.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
				else                  ctrl.illegal = (funct7 != F7_BASE);
			end
			OP_IMM: begin
				ctrl.reg_write = 1'b1;
				ctrl.src2_imm  = 1'b1;
				ctrl.alu_op    = f3_op(funct3, (funct3 == 3'b101) && instr[30]);
				if (funct3 == 3'b001) ctrl.illegal = (funct7 != F7_BASE);   // slli
				else if (funct3 == 3'b101)   // srli / srai
					ctrl.illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
			end
			LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.src2_imm  = 1'b1;
				ctrl.alu_op    = ALU_PASS_B;
				ctrl.imm       = imm_u;
			end
			AUIPC: begin
				ctrl.reg_write = 1'b1;
				ctrl.src1_pc   = 1'b1;
				ctrl.src2_imm  = 1'b1;
				ctrl.imm       = imm_u;   // add pc + upper imm
			end
			BRANCH: begin
				ctrl.is_branch = 1'b1;
				ctrl.imm       = imm_b;
				case (funct3[2:1])
					2'b00:   ctrl.alu_op = ALU_SUB;    // beq/bne test zero
					2'b10:   ctrl.alu_op = ALU_SLT;    // blt/bge
					2'b11:   ctrl.alu_op = ALU_SLTU;   // bltu/bgeu
					default: ctrl.illegal = 1'b1;      // 010, 011
				endcase
			end
			JAL: begin
				ctrl.is_jal    = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.src1_pc   = 1'b1;
				ctrl.src2_imm  = 1'b1;
				ctrl.imm       = imm_j;
			end
			default: ctrl.illegal = 1'b1;   // unknown major opcode
		endcase
	end

endmodule

// ==== design/rv_alu.sv ====
//********************************************************************
// combinational ALU: add/sub, logic, masked shifts, compares, pass b
//********************************************************************
`include "rv_consts.svh"

module rv_alu
	import rv_pkg::*;
(
	input  logic [`XLEN-1:0] src1,
	input  logic [`XLEN-1:0] src2,
	input  alu_op_e          alu_op,
	output logic [`XLEN-1:0] result,
	output logic             zero
);

	localparam int SHW = $clog2(`XLEN);   // rv32 shift amount width
	localparam int MSB = `XLEN - 1;

	logic [`XLEN:0]   diff_ext;   // src1 - src2 with carry out on top
	logic [`XLEN-1:0] diff;
	logic             borrow;
	logic             sign;
	logic             ovf;
	logic             slt;
	logic             sltu;
	logic [SHW-1:0]   shamt;

	// one subtractor serves SUB, SLT and SLTU, always src1 - src2
	assign diff_ext = {1'b0, src1} + {1'b0, ~src2} + 1'b1;
	assign diff     = diff_ext[MSB:0];
	assign borrow   = ~diff_ext[`XLEN];   // no carry out means src1 < src2 unsigned

	assign sign = diff[MSB];
	// overflow only when operand signs differ and result sign flips from src1
	assign ovf  = (src1[MSB] ^ src2[MSB]) & (sign ^ src1[MSB]);

	assign slt  = sign ^ ovf;   // true signed less-than
	assign sltu = borrow;

	assign shamt = src2[SHW-1:0];   // shifts only see low five bits

	always_comb begin
		case (alu_op)
			ALU_ADD:    result = src1 + src2;
			ALU_SUB:    result = diff;
			ALU_SLL:    result = src1 << shamt;
			ALU_SLT:    result = {{(`XLEN-1){1'b0}}, slt};
			ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, sltu};
			ALU_XOR:    result = src1 ^ src2;
			ALU_SRL:    result = src1 >> shamt;
			ALU_SRA:    result = $signed(src1) >>> shamt;   // sign fill
			ALU_OR:     result = src1 | src2;
			ALU_AND:    result = src1 & src2;
			ALU_PASS_B: result = src2;
			default:    result = '0;   // unused codes
		endcase
	end

	assign zero = (result == '0);

	// beq/bne rely on zero after SUB meaning equal operands
	always_comb begin
		if (alu_op == ALU_SUB) begin
			assert final (zero == (src1 == src2))
				else $error("alu zero flag disagrees with operand equality");
		end
	end

	// signed and unsigned compare agree whenever both msbs match
	always_comb begin
		if (src1[MSB] == src2[MSB]) begin
			assert final (slt == sltu)
				else $error("alu slt and sltu diverge for same-sign operands");
		end
	end

endmodule

// ==== design/rv_pkg.sv ====
//********************************************************************
// shared types of the execute slice with ALU and major opcodes,
// the decoded control record and the registered write-back record
//********************************************************************
`include "rv_consts.svh"

package rv_pkg;

	// alu operation codes in fixed encoding order
	typedef enum logic [3:0] {
		ALU_ADD    = 4'b0000,
		ALU_SUB    = 4'b0001,
		ALU_SLL    = 4'b0010,
		ALU_SLT    = 4'b0011,
		ALU_SLTU   = 4'b0100,
		ALU_XOR    = 4'b0101,
		ALU_SRL    = 4'b0110,
		ALU_SRA    = 4'b0111,
		ALU_OR     = 4'b1000,
		ALU_AND    = 4'b1001,
		ALU_PASS_B = 4'b1010     // src2 straight through for lui
	} alu_op_e;

	// major opcodes in instr[6:0]
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcode_e;

	typedef struct packed {
		alu_op_e              alu_op;
		logic                 src1_pc;    // operand a is pc, not rs1
		logic                 src2_imm;   // operand b is imm, not rs2
		logic                 is_branch;
		logic                 is_jal;
		logic                 reg_write;
		logic [2:0]           funct3;     // branch condition select
		logic [`REG_AW-1:0]   rs1;
		logic [`REG_AW-1:0]   rs2;
		logic [`REG_AW-1:0]   rd;
		logic [`XLEN-1:0]     imm;
		logic                 illegal;
	} ctrl_t;

	// registered write-back record
	typedef struct packed {
		logic                 valid;
		logic [`REG_AW-1:0]   rd;
		logic [`XLEN-1:0]     data;
	} wb_t;

endpackage

// ==== design/rv_consts.svh ====
//********************************************************************
// global constants for the RV32I execute slice
//********************************************************************
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN      32             // data path width
`define REG_COUNT 32             // architectural registers x0..x31
`define REG_AW    5              // register index width

// pc loaded at reset
`define RESET_PC  32'h0000_0000

`endif
